/* bmem_line_reader.sv */
`timescale 1ns/1ps

module bmem_line_reader (
    input  logic             clk,
    input  logic             rst,

    input  logic             line_req_i,
    input  fetch_pkg::addr_t line_req_addr_i,

    output fetch_pkg::addr_t bmem_addr_o,
    output logic             bmem_read_o,
    input  logic             bmem_ready_i,
    input  fetch_pkg::addr_t bmem_raddr_i,
    input  fetch_pkg::beat_t bmem_rdata_i,
    input  logic             bmem_rvalid_i,

    output logic             busy_o,
    output logic             line_done_o,
    output fetch_pkg::line_t line_data_o,
    output fetch_pkg::addr_t line_addr_o
);

    import fetch_pkg::*;

    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

    logic      pend_q;
    logic      out_q;
    logic      done_q;
    beat_idx_t beat_cnt_q;
    addr_t     req_addr_q;
    addr_t     line_addr_q;
    line_t     line_q;

    // strobe goes out only while memory is ready
    assign bmem_read_o = pend_q && bmem_ready_i;
    assign bmem_addr_o = req_addr_q;

    assign busy_o      = pend_q || out_q;
    assign line_done_o = done_q;
    assign line_data_o = line_q;
    assign line_addr_o = line_addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q     <= 1'b0;
            out_q      <= 1'b0;
            done_q     <= 1'b0;
            beat_cnt_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (line_req_i && !busy_o) begin
                pend_q <= 1'b1;
            end
            if (bmem_read_o) begin
                pend_q     <= 1'b0;
                out_q      <= 1'b1;
                beat_cnt_q <= '0;
            end
            if (out_q && bmem_rvalid_i) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                // fourth beat closes the burst
                if (beat_cnt_q == beat_idx_t'(BEATS_PER_LINE - 1)) begin
                    out_q  <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // request address and line payload
    always_ff @(posedge clk) begin
        if (line_req_i && !busy_o) begin
            req_addr_q <= line_req_addr_i;
        end
        if (out_q && bmem_rvalid_i) begin
            line_q[beat_cnt_q*$bits(beat_t) +: $bits(beat_t)] <= bmem_rdata_i;
            line_addr_q <= bmem_raddr_i;
        end
    end

endmodule

/* fetch_assert.sv */
`timescale 1ns/1ps

module fetch_assert (
    input logic              clk,
    input logic              rst,
    input logic              bmem_read_i,
    input logic              bmem_ready_i,
    input logic              line_done_i,
    input logic              push_i,
    input logic              queue_full_i,
    input logic              inst_valid_i,
    input fetch_pkg::inst_t  inst_i,
    input fetch_pkg::addr_t  inst_pc_i,
    input fetch_pkg::order_t inst_order_i,
    input logic              inst_take_i,
    input logic              redirect_i
);

    // open from the read strobe until the line is delivered
    logic read_open_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_open_q <= 1'b0;
        end else if (bmem_read_i) begin
            read_open_q <= 1'b1;
        end else if (line_done_i) begin
            read_open_q <= 1'b0;
        end
    end

    read_needs_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_ready_i)
        else $error("read strobe without bmem_ready");

    one_read_open: assert property (@(posedge clk) disable iff (rst)
        read_open_q |-> !bmem_read_i)
        else $error("read strobe while a read is outstanding");

    head_stable: assert property (@(posedge clk) disable iff (rst)
        (inst_valid_i && !inst_take_i && !redirect_i) |=>
        (inst_valid_i && $stable(inst_i) && $stable(inst_pc_i) && $stable(inst_order_i)))
        else $error("queue head changed without a take");

    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push_i |-> !queue_full_i)
        else $error("push into a full queue");

endmodule

bind fetch_top fetch_assert i_fetch_assert (
    .clk          (clk),
    .rst          (rst),
    .bmem_read_i  (bmem_read_o),
    .bmem_ready_i (bmem_ready_i),
    .line_done_i  (line_done),
    .push_i       (push),
    .queue_full_i (queue_full),
    .inst_valid_i (inst_valid_o),
    .inst_i       (inst_o),
    .inst_pc_i    (inst_pc_o),
    .inst_order_i (inst_order_o),
    .inst_take_i  (inst_take_i),
    .redirect_i   (redirect_i)
);

/* fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic             clk,
    input  logic             rst,

    input  logic             redirect_i,
    input  fetch_pkg::addr_t redirect_pc_i,

    input  logic             hit_i,
    input  fetch_pkg::inst_t hit_word_i,
    output fetch_pkg::addr_t pc_o,

    output logic             line_req_o,
    output fetch_pkg::addr_t line_req_addr_o,
    input  logic             reader_busy_i,
    input  logic             line_done_i,

    output logic             push_o,
    output fetch_pkg::addr_t push_pc_o,
    output fetch_pkg::inst_t push_inst_o,
    input  logic             queue_full_i
);

    import fetch_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_d;
    addr_t        pc_q;
    addr_t        pc_d;

    always_comb begin
        state_d    = state_q;
        pc_d       = pc_q;
        push_o     = 1'b0;
        line_req_o = 1'b0;

        case (state_q)
            FETCH_RUN: begin
                if (redirect_i) begin
                    pc_d = redirect_pc_i;
                end else if (hit_i) begin
                    // hold pc while queue is full
                    if (!queue_full_i) begin
                        push_o = 1'b1;
                        pc_d   = pc_q + 32'd4;
                    end
                end else begin
                    state_d = FETCH_MISS;
                end
            end

            FETCH_MISS: begin
                if (redirect_i) begin
                    // nothing requested yet, retry from new pc
                    pc_d    = redirect_pc_i;
                    state_d = FETCH_RUN;
                end else if (!reader_busy_i) begin
                    line_req_o = 1'b1;
                    state_d    = FETCH_FILL;
                end
            end

            FETCH_FILL: begin
                // a fill in flight always runs to completion
                if (redirect_i) begin
                    pc_d = redirect_pc_i;
                end
                if (line_done_i) begin
                    state_d = FETCH_RUN;
                end
            end

            default: begin
                state_d = FETCH_RUN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FETCH_RUN;
            pc_q    <= RESET_PC;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // line aligned request
    assign line_req_addr_o = {pc_q[31:5], 5'b0};

    assign push_pc_o   = pc_q;
    assign push_inst_o = hit_word_i;

endmodule

/* fetch_line_buffer.sv */
`timescale 1ns/1ps

module fetch_line_buffer (
    input  logic             clk,
    input  logic             rst,

    input  logic             fill_i,
    input  fetch_pkg::line_t fill_data_i,
    input  fetch_pkg::addr_t fill_addr_i,

    input  fetch_pkg::addr_t pc_i,
    output logic             hit_o,
    output fetch_pkg::inst_t hit_word_o
);

    import fetch_pkg::*;

    logic      valid_q;
    line_tag_t tag_q;
    line_t     data_q;

    line_tag_t pc_tag;
    word_sel_t pc_word;

    assign pc_tag  = pc_i[31:5];
    assign pc_word = pc_i[4:2];

    // valid bit alone marks an empty buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (fill_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q  <= fill_addr_i[31:5];
            data_q <= fill_data_i;
        end
    end

    assign hit_o      = valid_q && (tag_q == pc_tag);
    assign hit_word_o = data_q[pc_word*$bits(inst_t) +: $bits(inst_t)];

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    // line geometry
    localparam int BEATS_PER_LINE = 4;
    localparam int WORDS_PER_LINE = 8;

    // instruction queue size
    localparam int QUEUE_DEPTH = 8;

    // first fetch address after reset
    localparam logic [31:0] RESET_PC = 32'haaaaa000;

    // byte address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // sequence number given at dequeue
    typedef logic [31:0] order_t;

    // one burst beat and one full line
    typedef logic [63:0] beat_t;
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;

    // addr[31:5] and addr[4:2]
    typedef logic [26:0] line_tag_t;
    typedef logic [2:0] word_sel_t;

    typedef enum logic [1:0] {
        FETCH_RUN,
        FETCH_MISS,
        FETCH_FILL
    } fetch_state_t;

endpackage

/* fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

    import fetch_pkg::*;

    logic        clk = 1'b0;
    logic        rst;

    addr_t       bmem_addr_o;
    logic        bmem_read_o;
    logic        bmem_ready_i;
    addr_t       bmem_raddr_i;
    beat_t       bmem_rdata_i;
    logic        bmem_rvalid_i;
    logic        redirect_i;
    addr_t       redirect_pc_i;
    logic        inst_valid_o;
    inst_t       inst_o;
    addr_t       inst_pc_o;
    order_t      inst_order_o;
    logic        inst_take_i;

    // trace contents
    inst_t       mem_img [addr_t];
    logic [7:0]  cmd_kind [$];
    logic [31:0] cmd_arg [$];
    int unsigned total_takes;
    int unsigned total_jumps;
    int unsigned cycle_limit = 32'hffff_ffff;
    int unsigned cycle_cnt = 0;

    // reference state for the head of the queue
    addr_t       exp_pc;
    order_t      exp_order;
    int unsigned taken_cnt;
    int unsigned hold_cnt;

    // burst memory model
    logic        rd_busy;
    addr_t       rd_addr;
    int unsigned rd_beat;
    int unsigned rd_wait;
    addr_t       last_read;
    logic        have_last;
    int unsigned read_cnt;

    logic [15:0] lfsr = 16'd67;
    int unsigned mismatch_cnt;
    int unsigned other_err_cnt;

    fetch_top i_fetch_top (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .inst_valid_o  (inst_valid_o),
        .inst_o        (inst_o),
        .inst_pc_o     (inst_pc_o),
        .inst_order_o  (inst_order_o),
        .inst_take_i   (inst_take_i)
    );

    always #4 clk = ~clk;

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | 32'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    // unlisted words read as the inverse of their address
    function automatic inst_t mem_word(input addr_t a);
        if (mem_img.exists(a)) begin
            return mem_img[a];
        end
        return ~a;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_trace(output logic ok);
        int          fd;
        int          code;
        int          ch;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] w;
        logic        more;
        ok = 1'b0;
        fd = $fopen("fetch_trace.txt", "r");
        if (fd != 0) begin
            ok   = 1'b1;
            more = 1'b1;
            while (more) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    more = 1'b0;
                end else if (kind == "#") begin
                    // skip the rest of a comment line up to newline or end of file
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (kind == "M") begin
                    code = $fscanf(fd, " %h %h", a, w);
                    mem_img[a] = w;
                end else if (kind == "T") begin
                    code = $fscanf(fd, " %d", a);
                    cmd_kind.push_back(kind);
                    cmd_arg.push_back(a);
                    total_takes += a;
                end else if (kind == "J") begin
                    code = $fscanf(fd, " %h", a);
                    cmd_kind.push_back(kind);
                    cmd_arg.push_back(a);
                    total_jumps++;
                end else begin
                    $display("Error: trace line of unknown kind %c", kind);
                    other_err_cnt++;
                    more = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    // drive 1 ns after the rising edge and sample at the falling edge
    task automatic step_cycle(input logic want_take, input logic redir, input addr_t redir_pc);
        @(posedge clk);
        #1;
        cycle_cnt++;
        redirect_i    = redir;
        redirect_pc_i = redir_pc;
        inst_take_i   = 1'b0;
        if (hold_cnt != 0) begin
            hold_cnt--;
        end else if (want_take && !redir) begin
            inst_take_i = (rand_bits(2) == 0);
        end
        bmem_ready_i  = (rand_bits(1) != 0);
        bmem_rvalid_i = 1'b0;
        if (rd_busy) begin
            if (rd_wait != 0) begin
                rd_wait--;
            end else if (rand_bits(1) != 0) begin
                // beat n carries words 2n and 2n+1 of the line
                bmem_rvalid_i = 1'b1;
                bmem_raddr_i  = rd_addr;
                bmem_rdata_i  = {mem_word(rd_addr + 8 * rd_beat + 4),
                                 mem_word(rd_addr + 8 * rd_beat)};
                rd_beat++;
                rd_busy = (rd_beat != BEATS_PER_LINE);
            end
        end

        @(negedge clk);
        if (bmem_read_o) begin
            read_cnt++;
            check_value("read address bits 4:0", {27'b0, bmem_addr_o[4:0]}, 32'h0);
            if (rd_busy) begin
                $display("Error at %0d ns: read strobe while a read is outstanding", $time);
                other_err_cnt++;
            end
            if (have_last && bmem_addr_o == last_read) begin
                $display("Error at %0d ns: line %h read twice in a row", $time, bmem_addr_o);
                other_err_cnt++;
            end
            last_read = bmem_addr_o;
            have_last = 1'b1;
            rd_busy   = 1'b1;
            rd_addr   = bmem_addr_o;
            rd_beat   = 0;
            rd_wait   = 2 + rand_bits(3);
        end
        if (inst_take_i && inst_valid_o) begin
            check_value("inst_pc_o", inst_pc_o, exp_pc);
            check_value("inst_o", inst_o, mem_word(exp_pc));
            check_value("inst_order_o", inst_order_o, exp_order);
            exp_pc    = exp_pc + 32'd4;
            exp_order = exp_order + 32'd1;
            taken_cnt++;
            // now and then a long pause without takes
            if (rand_bits(3) == 0) begin
                hold_cnt = 12 + rand_bits(4);
            end
        end
    endtask

    task automatic take_insts(input int unsigned n);
        int unsigned goal;
        goal = taken_cnt + n;
        while (taken_cnt < goal) begin
            step_cycle(1'b1, 1'b0, '0);
        end
    endtask

    task automatic redirect_to(input addr_t pc);
        step_cycle(1'b0, 1'b1, pc);
        exp_pc = pc;
        step_cycle(1'b0, 1'b0, '0);
        check_value("inst_valid_o after redirect", 32'(inst_valid_o), 32'h0);
    endtask

    initial begin
        wait (cycle_cnt >= cycle_limit);
        $display("Timeout: no progress after %0d cycles, %0d of %0d instructions taken",
                 cycle_cnt, taken_cnt, total_takes);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        logic ok;
        rst           = 1'b1;
        bmem_ready_i  = 1'b1;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        bmem_rvalid_i = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        inst_take_i   = 1'b0;
        exp_pc        = RESET_PC;
        exp_order     = '0;
        taken_cnt     = 0;
        hold_cnt      = 0;
        rd_busy       = 1'b0;
        rd_addr       = '0;
        rd_beat       = 0;
        rd_wait       = 0;
        last_read     = '0;
        have_last     = 1'b0;
        read_cnt      = 0;
        mismatch_cnt  = 0;
        other_err_cnt = 0;
        total_takes   = 0;
        total_jumps   = 0;

        load_trace(ok);
        if (!ok) begin
            $display("Error: cannot open fetch_trace.txt");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            // bound per instruction covers a miss plus pauses in takes
            cycle_limit = total_takes * 64 + total_jumps * 32 + 200;
            repeat (3) @(posedge clk);
            #1;
            rst = 1'b0;
            @(negedge clk);
            check_value("inst_valid_o after reset", 32'(inst_valid_o), 32'h0);
            check_value("bmem_read_o after reset", 32'(bmem_read_o), 32'h0);

            for (int i = 0; i < cmd_kind.size(); i++) begin
                if (cmd_kind[i] == "T") begin
                    take_insts(cmd_arg[i]);
                end else begin
                    redirect_to(cmd_arg[i]);
                end
            end
            if (read_cnt == 0) begin
                $display("Error: no memory read was issued");
                other_err_cnt++;
            end

            $display("errors: %0d mismatches, %0d other (%0d instructions, %0d reads)",
                     mismatch_cnt, other_err_cnt, taken_cnt, read_cnt);
            if (mismatch_cnt == 0 && other_err_cnt == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic              clk,
    input  logic              rst,

    output fetch_pkg::addr_t  bmem_addr_o,
    output logic              bmem_read_o,
    input  logic              bmem_ready_i,
    input  fetch_pkg::addr_t  bmem_raddr_i,
    input  fetch_pkg::beat_t  bmem_rdata_i,
    input  logic              bmem_rvalid_i,

    input  logic              redirect_i,
    input  fetch_pkg::addr_t  redirect_pc_i,

    output logic              inst_valid_o,
    output fetch_pkg::inst_t  inst_o,
    output fetch_pkg::addr_t  inst_pc_o,
    output fetch_pkg::order_t inst_order_o,
    input  logic              inst_take_i
);

    import fetch_pkg::*;

    // reader side
    logic  line_req;
    addr_t line_req_addr;
    logic  reader_busy;
    logic  line_done;
    line_t line_data;
    addr_t line_addr;

    // line buffer lookup
    addr_t pc;
    logic  line_hit;
    inst_t hit_word;

    // queue write side
    logic  push;
    addr_t push_pc;
    inst_t push_inst;
    logic  queue_full;

    bmem_line_reader i_reader (
        .clk             (clk),
        .rst             (rst),
        .line_req_i      (line_req),
        .line_req_addr_i (line_req_addr),
        .bmem_addr_o     (bmem_addr_o),
        .bmem_read_o     (bmem_read_o),
        .bmem_ready_i    (bmem_ready_i),
        .bmem_raddr_i    (bmem_raddr_i),
        .bmem_rdata_i    (bmem_rdata_i),
        .bmem_rvalid_i   (bmem_rvalid_i),
        .busy_o          (reader_busy),
        .line_done_o     (line_done),
        .line_data_o     (line_data),
        .line_addr_o     (line_addr)
    );

    fetch_line_buffer i_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .fill_i      (line_done),
        .fill_data_i (line_data),
        .fill_addr_i (line_addr),
        .pc_i        (pc),
        .hit_o       (line_hit),
        .hit_word_o  (hit_word)
    );

    fetch_ctrl i_ctrl (
        .clk             (clk),
        .rst             (rst),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .hit_i           (line_hit),
        .hit_word_i      (hit_word),
        .pc_o            (pc),
        .line_req_o      (line_req),
        .line_req_addr_o (line_req_addr),
        .reader_busy_i   (reader_busy),
        .line_done_i     (line_done),
        .push_o          (push),
        .push_pc_o       (push_pc),
        .push_inst_o     (push_inst),
        .queue_full_i    (queue_full)
    );

    inst_queue i_queue (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect_i),
        .push_i      (push),
        .push_pc_i   (push_pc),
        .push_inst_i (push_inst),
        .full_o      (queue_full),
        .take_i      (inst_take_i),
        .valid_o     (inst_valid_o),
        .inst_o      (inst_o),
        .pc_o        (inst_pc_o),
        .order_o     (inst_order_o)
    );

endmodule

/* fetch_trace.txt */
# columns: M <addr hex> <word hex> | T <count decimal> | J <pc hex>
# M sets a memory word, T takes and checks instructions, J redirects fetch
M aaaaa000 00000013
M aaaaa004 00100093
M aaaaa008 00208113
M aaaaa01c 0000006f
M aaaaa020 deadbeef
M aaaaa03c 00c58633
M aaaaa0fc 0ff0000f
M aaaaa100 00000073
M 10000040 cafe0001
M 10000044 cafe0002
M 1000005c cafe0017
M 10000060 cafe0018
T 24
T 16
J 10000040
T 2
J 10000060
T 9
J 10000044
T 5
J aaaaa0f8
T 6

/* inst_queue.sv */
`timescale 1ns/1ps

module inst_queue (
    input  logic              clk,
    input  logic              rst,

    input  logic              flush_i,

    input  logic              push_i,
    input  fetch_pkg::addr_t  push_pc_i,
    input  fetch_pkg::inst_t  push_inst_i,
    output logic              full_o,

    input  logic              take_i,
    output logic              valid_o,
    output fetch_pkg::inst_t  inst_o,
    output fetch_pkg::addr_t  pc_o,
    output fetch_pkg::order_t order_o
);

    import fetch_pkg::*;

    addr_t  pc_mem   [QUEUE_DEPTH];
    inst_t  inst_mem [QUEUE_DEPTH];

    logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(QUEUE_DEPTH):0]   count_q;
    order_t                         order_q;

    logic do_push;
    logic do_take;

    assign full_o  = (count_q == QUEUE_DEPTH);
    assign valid_o = (count_q != '0);

    assign do_push = push_i && !full_o;
    assign do_take = take_i && valid_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr_q]   <= push_pc_i;
            inst_mem[wr_ptr_q] <= push_inst_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_take) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_push && !do_take) begin
                count_q <= count_q + 1'b1;
            end else if (do_take && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // numbers advance only on dequeue, flush leaves them alone
    always_ff @(posedge clk) begin
        if (rst) begin
            order_q <= '0;
        end else if (do_take) begin
            order_q <= order_q + 32'd1;
        end
    end

    assign inst_o  = inst_mem[rd_ptr_q];
    assign pc_o    = pc_mem[rd_ptr_q];
    assign order_o = order_q;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f src.f -o fetch_sim
./obj_dir/fetch_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* src.f */
fetch_pkg.sv
bmem_line_reader.sv
fetch_line_buffer.sv
fetch_ctrl.sv
inst_queue.sv
fetch_top.sv
fetch_assert.sv
fetch_tb.sv
